//--- src/spiflash_defines.svh
`ifndef SPIFLASH_DEFINES_SVH
`define SPIFLASH_DEFINES_SVH

`define SPIFLASH_ADDR_W 24
`define SPIFLASH_DATA_W 32
`define SPIFLASH_TAG_W 3

// flash command bytes
`define SPIFLASH_CMD_WAKE0 8'hFF
`define SPIFLASH_CMD_WAKE1 8'hAB
`define SPIFLASH_CMD_READ 8'h03
`define SPIFLASH_CMD_QREAD 8'hEB
`define SPIFLASH_MODE_BYTE 8'hFF

`define SPIFLASH_DUMMY_RST 8

// writable bits: en, qspi, dummy, oe, csb, clk, dout
`define SPIFLASH_CFG_WMASK 32'h802F_0F3F

`endif

//--- src/spiflash_pkg.sv
package spiflash_pkg;

    typedef struct packed {
        logic       en;         // 31
        logic [8:0] rsvd_hi;
        logic       qspi;       // 21
        logic       rsvd_mid;
        logic [3:0] dummy;      // 19:16
        logic [3:0] rsvd_lo;
        logic [3:0] oe;         // 11:8
        logic [1:0] rsvd_pin;
        logic       csb;        // 5
        logic       clk;        // 4
        logic [3:0] dout;       // 3:0
    } cfgreg_fields_s;

    typedef union packed {
        logic [3:0][7:0] lanes;     // byte strobe view
        cfgreg_fields_s  fields;
    } cfgreg_u;

    typedef enum logic {
        XFER_SINGLE = 1'b0,
        XFER_QUAD   = 1'b1
    } xfer_mode_e;

endpackage

//--- src/spiflash_cfg.sv
`timescale 1ns/1ps
`include "spiflash_defines.svh"

module spiflash_cfg (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [3:0]            cfg_we_i,
    input  spiflash_pkg::cfgreg_u cfg_wdata_i,
    input  logic                  pin_csb_i,
    input  logic                  pin_clk_i,
    input  logic [3:0]            pin_oe_i,
    input  logic [3:0]            pin_di_i,
    output spiflash_pkg::cfgreg_u cfg_o,
    output spiflash_pkg::cfgreg_u cfg_rdata_o,
    output logic                  soft_rst_o
);
    localparam logic [31:0] WMASK = `SPIFLASH_CFG_WMASK;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cfg_o <= '0;
            cfg_o.fields.en <= 1'b1;
            cfg_o.fields.dummy <= 4'(`SPIFLASH_DUMMY_RST);
            soft_rst_o <= 1'b1;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (cfg_we_i[i]) begin
                    cfg_o.lanes[i] <= cfg_wdata_i.lanes[i] & WMASK[i*8 +: 8];
                end
            end
            soft_rst_o <= |cfg_we_i || !cfg_o.fields.en;    // bit-bang holds core idle
        end
    end

    // pin fields read back live
    always_comb begin
        cfg_rdata_o = cfg_o;
        cfg_rdata_o.fields.csb = pin_csb_i;
        cfg_rdata_o.fields.clk = pin_clk_i;
        cfg_rdata_o.fields.oe = pin_oe_i;
        cfg_rdata_o.fields.dout = pin_di_i;
    end

    // byte strobes are single-cycle pulses
    assert property (@(posedge clk) disable iff (!resetn)
        |cfg_we_i |=> !(|cfg_we_i));

endmodule

//--- src/spiflash_xfer.sv
`timescale 1ns/1ps
`include "spiflash_defines.svh"

module spiflash_xfer (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       xfer_rst_i,
    input  logic                       din_valid_i,
    output logic                       din_ready_o,
    input  logic [7:0]                 din_data_i,
    input  logic [`SPIFLASH_TAG_W-1:0] din_tag_i,
    input  spiflash_pkg::xfer_mode_e   din_mode_i,
    input  logic                       din_rd_i,
    output logic                       dout_valid_o,
    output logic [7:0]                 dout_data_o,
    output logic [`SPIFLASH_TAG_W-1:0] dout_tag_o,
    output logic                       sck_o,
    output logic                       csb_o,
    output logic [3:0]                 io_oe_o,
    output logic [3:0]                 io_do_o,
    input  logic [3:0]                 io_di_i
);
    logic [3:0]                 bit_cnt;    // bits left in byte
    logic [3:0]                 dummy_cnt;
    logic [3:0]                 step;
    logic [7:0]                 obuf;
    logic [7:0]                 ibuf;
    logic                       quad;
    logic                       idle;
    logic                       rd_q;
    logic [`SPIFLASH_TAG_W-1:0] tag_q;
    spiflash_pkg::xfer_mode_e   mode_q;

    assign quad = (mode_q == spiflash_pkg::XFER_QUAD);
    assign step = quad ? 4'd4 : 4'd1;
    assign idle = (bit_cnt == 4'd0) && (dummy_cnt == 4'd0);
    assign din_ready_o = din_valid_i && idle;
    assign dout_data_o = ibuf;
    assign dout_tag_o = tag_q;

    // quad read data leaves the lines to the flash
    assign io_oe_o = quad ? {4{!rd_q}} : 4'b0001;
    assign io_do_o = quad ? obuf[7:4] : {3'b000, obuf[7]};

    always_ff @(posedge clk) begin
        if (!resetn || xfer_rst_i) begin
            csb_o <= 1'b1;
            sck_o <= 1'b0;
            bit_cnt <= 4'd0;
            dummy_cnt <= 4'd0;
            dout_valid_o <= 1'b0;
            tag_q <= '0;
            mode_q <= spiflash_pkg::XFER_SINGLE;
            rd_q <= 1'b0;
        end else begin
            dout_valid_o <= 1'b0;
            if (dummy_cnt != 4'd0) begin
                sck_o <= !sck_o;
                if (sck_o) begin
                    dummy_cnt <= dummy_cnt - 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                sck_o <= !sck_o;
                if (sck_o) begin    // falling edge, next bits out
                    obuf <= quad ? {obuf[3:0], 4'b0000} : {obuf[6:0], 1'b0};
                    bit_cnt <= bit_cnt - step;
                    dout_valid_o <= (bit_cnt == step);
                end else begin
                    ibuf <= quad ? {ibuf[3:0], io_di_i} : {ibuf[6:0], io_di_i[1]};
                end
            end
            if (din_ready_o) begin
                csb_o <= 1'b0;
                sck_o <= 1'b0;
                bit_cnt <= 4'd8;
                dummy_cnt <= din_rd_i ? din_data_i[3:0] : 4'd0;
                obuf <= din_data_i;
                tag_q <= din_tag_i;
                mode_q <= din_mode_i;
                rd_q <= din_rd_i;
            end
        end
    end

    // requests are not withdrawn unless the engine is aborted
    assert property (@(posedge clk) disable iff (!resetn)
        din_valid_i && !din_ready_o && !xfer_rst_i |=> din_valid_i || xfer_rst_i);

endmodule

//--- src/spiflash_seq.sv
`timescale 1ns/1ps
`include "spiflash_defines.svh"

module spiflash_seq (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        soft_rst_i,
    input  logic                        valid_i,
    output logic                        ready_o,
    input  logic [`SPIFLASH_ADDR_W-1:0] addr_i,
    output logic [`SPIFLASH_DATA_W-1:0] rdata_o,
    input  spiflash_pkg::cfgreg_u       cfg_i,
    output logic                        xfer_rst_o,
    output logic                        din_valid_o,
    input  logic                        din_ready_i,
    output logic [7:0]                  din_data_o,
    output logic [`SPIFLASH_TAG_W-1:0]  din_tag_o,
    output spiflash_pkg::xfer_mode_e    din_mode_o,
    output logic                        din_rd_o,
    input  logic                        dout_valid_i,
    input  logic [7:0]                  dout_data_i,
    input  logic [`SPIFLASH_TAG_W-1:0]  dout_tag_i
);
    localparam logic [3:0] S_WAKE0   = 4'd0;
    localparam logic [3:0] S_WAKE0_W = 4'd1;
    localparam logic [3:0] S_WAKE1   = 4'd2;
    localparam logic [3:0] S_WAKE1_W = 4'd3;
    localparam logic [3:0] S_CMD     = 4'd4;
    localparam logic [3:0] S_ADDR2   = 4'd5;
    localparam logic [3:0] S_ADDR1   = 4'd6;
    localparam logic [3:0] S_ADDR0   = 4'd7;
    localparam logic [3:0] S_MODE    = 4'd8;
    localparam logic [3:0] S_DATA1   = 4'd9;
    localparam logic [3:0] S_DATA2   = 4'd10;
    localparam logic [3:0] S_DATA3   = 4'd11;
    localparam logic [3:0] S_DATA4   = 4'd12;
    localparam logic [`SPIFLASH_ADDR_W-1:0] WORD_STEP = 4;

    logic [3:0]                  state;
    logic [3:0]                  next_state;
    logic [`SPIFLASH_ADDR_W-1:0] rd_addr;
    logic [23:0]                 buffer;
    logic                        rd_valid;
    logic                        rd_wait;    // prefetched word not yet asked for
    logic                        rd_inc;
    logic                        first_q;    // dummy clocks still owed
    logic                        rst_q;
    logic                        jump;
    logic                        qspi;

    assign qspi = cfg_i.fields.qspi;
    assign ready_o = valid_i && rd_valid && (addr_i == rd_addr);
    assign jump = valid_i && !ready_o && rd_valid && (addr_i != rd_addr + WORD_STEP);
    assign xfer_rst_o = jump || rst_q;

    always_comb begin
        din_valid_o = 1'b1;
        din_data_o = 8'h00;
        din_tag_o = 3'd0;
        din_mode_o = (qspi && state >= S_ADDR2) ? spiflash_pkg::XFER_QUAD
                                                : spiflash_pkg::XFER_SINGLE;
        din_rd_o = qspi && (state >= S_DATA1);
        next_state = state + 4'd1;
        case (state)
            S_WAKE0: din_data_o = `SPIFLASH_CMD_WAKE0;
            S_WAKE1: din_data_o = `SPIFLASH_CMD_WAKE1;
            S_WAKE0_W, S_WAKE1_W: din_valid_o = 1'b0;
            S_CMD: din_data_o = qspi ? `SPIFLASH_CMD_QREAD : `SPIFLASH_CMD_READ;
            S_ADDR2: begin
                din_valid_o = valid_i && !ready_o;  // cs held low until asked
                din_data_o = addr_i[23:16];
            end
            S_ADDR1: din_data_o = addr_i[15:8];
            S_ADDR0: begin
                din_data_o = addr_i[7:0];
                next_state = qspi ? S_MODE : S_DATA1;
            end
            S_MODE: din_data_o = `SPIFLASH_MODE_BYTE;
            S_DATA1: begin
                din_tag_o = 3'd1;
                din_data_o = first_q ? {4'h0, cfg_i.fields.dummy} : 8'h00;
            end
            S_DATA2: din_tag_o = 3'd2;
            S_DATA3: din_tag_o = 3'd3;
            default: begin
                din_valid_o = !rd_wait || valid_i;  // hold back last byte
                din_tag_o = 3'd4;
                next_state = S_DATA1;
            end
        endcase
        din_valid_o = din_valid_o && !rst_q;
    end

    always_ff @(posedge clk) begin
        if (!resetn || soft_rst_i) begin
            state <= S_WAKE0;
            rst_q <= 1'b1;
            rd_valid <= 1'b0;
            rd_wait <= 1'b0;
            rd_inc <= 1'b0;
            first_q <= 1'b0;
        end else begin
            rst_q <= 1'b0;
            if (din_valid_o && din_ready_i) begin
                state <= next_state;
                if (state == S_MODE) begin
                    first_q <= 1'b1;
                end
                if (state == S_DATA1) begin
                    first_q <= 1'b0;
                end
            end
            // wake bytes each get their own chip select
            if ((state == S_WAKE0_W || state == S_WAKE1_W) && dout_valid_i) begin
                rst_q <= 1'b1;
                state <= next_state;
            end
            if (dout_valid_i && dout_tag_i == 3'd4) begin
                rd_addr <= rd_inc ? rd_addr + WORD_STEP : addr_i;
                rd_valid <= 1'b1;
                rd_wait <= rd_inc;
                rd_inc <= 1'b1;
            end
            if (valid_i) begin
                rd_wait <= 1'b0;
            end
            if (jump) begin
                state <= S_CMD;
                rd_valid <= 1'b0;
                rd_inc <= 1'b0;
            end
        end
    end

    // bytes arrive lsb first
    always_ff @(posedge clk) begin
        if (dout_valid_i) begin
            case (dout_tag_i)
                3'd1: buffer[7:0] <= dout_data_i;
                3'd2: buffer[15:8] <= dout_data_i;
                3'd3: buffer[23:16] <= dout_data_i;
                3'd4: rdata_o <= {dout_data_i, buffer};
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!resetn || soft_rst_i)
        ready_o ##1 (ready_o && $stable(addr_i)) |-> $stable(rdata_o));

endmodule

//--- src/spiflash_pads.sv
`timescale 1ns/1ps

module spiflash_pads (
    input  logic                  resetn,
    input  spiflash_pkg::cfgreg_u cfg_i,
    input  logic                  xfer_csb_i,
    input  logic                  xfer_sck_i,
    input  logic [3:0]            xfer_oe_i,
    input  logic [3:0]            xfer_do_i,
    output logic                  flash_csb_o,
    output logic                  flash_clk_o,
    output logic [3:0]            flash_io_oe_o,
    output logic [3:0]            flash_io_do_o
);
    logic bitbang;

    assign bitbang = !cfg_i.fields.en;

    assign flash_csb_o = bitbang ? cfg_i.fields.csb : xfer_csb_i;
    assign flash_clk_o = bitbang ? cfg_i.fields.clk : xfer_sck_i;
    assign flash_io_do_o = bitbang ? cfg_i.fields.dout : xfer_do_i;

    // no pad drives while the chip is in reset
    assign flash_io_oe_o = !resetn ? 4'b0000 : (bitbang ? cfg_i.fields.oe : xfer_oe_i);

endmodule

//--- src/spiflash_top.sv
`timescale 1ns/1ps
`include "spiflash_defines.svh"

module spiflash_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid_i,
    output logic                        ready_o,
    input  logic [`SPIFLASH_ADDR_W-1:0] addr_i,
    output logic [`SPIFLASH_DATA_W-1:0] rdata_o,
    input  logic [3:0]                  cfg_we_i,
    input  spiflash_pkg::cfgreg_u       cfg_wdata_i,
    output spiflash_pkg::cfgreg_u       cfg_rdata_o,
    output logic                        flash_csb_o,
    output logic                        flash_clk_o,
    output logic [3:0]                  flash_io_oe_o,
    output logic [3:0]                  flash_io_do_o,
    input  logic [3:0]                  flash_io_di_i
);
    spiflash_pkg::cfgreg_u      cfg;
    logic                       soft_rst;
    logic                       xfer_rst;
    logic                       din_valid;
    logic                       din_ready;
    logic [7:0]                 din_data;
    logic [`SPIFLASH_TAG_W-1:0] din_tag;
    spiflash_pkg::xfer_mode_e   din_mode;
    logic                       din_rd;
    logic                       dout_valid;
    logic [7:0]                 dout_data;
    logic [`SPIFLASH_TAG_W-1:0] dout_tag;
    logic                       xfer_csb;
    logic                       xfer_sck;
    logic [3:0]                 xfer_oe;
    logic [3:0]                 xfer_do;

    spiflash_cfg u_cfg (
        .clk         (clk),
        .resetn      (resetn),
        .cfg_we_i    (cfg_we_i),
        .cfg_wdata_i (cfg_wdata_i),
        .pin_csb_i   (flash_csb_o),
        .pin_clk_i   (flash_clk_o),
        .pin_oe_i    (flash_io_oe_o),
        .pin_di_i    (flash_io_di_i),
        .cfg_o       (cfg),
        .cfg_rdata_o (cfg_rdata_o),
        .soft_rst_o  (soft_rst)
    );

    spiflash_seq u_seq (
        .clk          (clk),
        .resetn       (resetn),
        .soft_rst_i   (soft_rst),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .addr_i       (addr_i),
        .rdata_o      (rdata_o),
        .cfg_i        (cfg),
        .xfer_rst_o   (xfer_rst),
        .din_valid_o  (din_valid),
        .din_ready_i  (din_ready),
        .din_data_o   (din_data),
        .din_tag_o    (din_tag),
        .din_mode_o   (din_mode),
        .din_rd_o     (din_rd),
        .dout_valid_i (dout_valid),
        .dout_data_i  (dout_data),
        .dout_tag_i   (dout_tag)
    );

    spiflash_xfer u_xfer (
        .clk          (clk),
        .resetn       (resetn),
        .xfer_rst_i   (xfer_rst),
        .din_valid_i  (din_valid),
        .din_ready_o  (din_ready),
        .din_data_i   (din_data),
        .din_tag_i    (din_tag),
        .din_mode_i   (din_mode),
        .din_rd_i     (din_rd),
        .dout_valid_o (dout_valid),
        .dout_data_o  (dout_data),
        .dout_tag_o   (dout_tag),
        .sck_o        (xfer_sck),
        .csb_o        (xfer_csb),
        .io_oe_o      (xfer_oe),
        .io_do_o      (xfer_do),
        .io_di_i      (flash_io_di_i)
    );

    spiflash_pads u_pads (
        .resetn        (resetn),
        .cfg_i         (cfg),
        .xfer_csb_i    (xfer_csb),
        .xfer_sck_i    (xfer_sck),
        .xfer_oe_i     (xfer_oe),
        .xfer_do_i     (xfer_do),
        .flash_csb_o   (flash_csb_o),
        .flash_clk_o   (flash_clk_o),
        .flash_io_oe_o (flash_io_oe_o),
        .flash_io_do_o (flash_io_do_o)
    );

endmodule

//--- testbench/flash_model.sv
`timescale 1ns/1ps
`include "spiflash_defines.svh"

module flash_model (
    input  logic       csb_i,
    input  logic       clk_i,
    input  logic [3:0] io_oe_i,
    input  logic [3:0] io_do_i,
    output logic [3:0] io_di_o,
    output logic [7:0] last_cmd_o,
    output logic       proto_err_o
);
    localparam int DUMMY = `SPIFLASH_DUMMY_RST;

    int          edges;     // rising edges since select
    int          k;
    logic        clk_q;
    logic [7:0]  cmd;
    logic [7:0]  mode;
    logic [7:0]  data;
    logic [23:0] addr;
    logic [23:0] byte_addr;
    logic [3:0]  drive;

    // driven lines win over the flash output
    assign io_di_o = (io_oe_i & io_do_i) | (~io_oe_i & drive);

    initial begin
        last_cmd_o = 8'h00;
        proto_err_o = 1'b0;
        clk_q = 1'b0;
    end

    always @(csb_i or clk_i) begin
        if (csb_i) begin
            edges = 0;
            cmd = 8'h00;
            mode = 8'h00;
            addr = '0;
            drive = 4'h0;
        end else if (clk_i && !clk_q) begin
            if (edges < 8) begin
                cmd = {cmd[6:0], io_do_i[0]};
                if (edges == 7) begin
                    last_cmd_o = cmd;
                    if (cmd != `SPIFLASH_CMD_WAKE0 && cmd != `SPIFLASH_CMD_WAKE1 &&
                        cmd != `SPIFLASH_CMD_READ && cmd != `SPIFLASH_CMD_QREAD) begin
                        proto_err_o = 1'b1;     // unknown command
                    end
                end
            end else if (cmd == `SPIFLASH_CMD_READ && edges < 32) begin
                addr = {addr[22:0], io_do_i[0]};
            end else if (cmd == `SPIFLASH_CMD_QREAD && edges < 14) begin
                addr = {addr[19:0], io_do_i};
            end else if (cmd == `SPIFLASH_CMD_QREAD && edges < 16) begin
                mode = {mode[3:0], io_do_i};
                if (edges == 15 && mode != `SPIFLASH_MODE_BYTE) begin
                    proto_err_o = 1'b1;
                end
            end
            edges = edges + 1;
        end else if (!clk_i && clk_q) begin
            // next data bits go out on the falling edge
            if (cmd == `SPIFLASH_CMD_READ && edges >= 32) begin
                k = edges - 32;
                byte_addr = addr + 24'(k / 8);
                data = byte_addr[7:0] ^ byte_addr[15:8] ^ 8'h5A;
                drive[1] = data[7 - (k % 8)];
            end else if (cmd == `SPIFLASH_CMD_QREAD && edges >= 16 + DUMMY) begin
                k = edges - 16 - DUMMY;
                byte_addr = addr + 24'(k / 2);
                data = byte_addr[7:0] ^ byte_addr[15:8] ^ 8'h5A;
                drive = (k % 2 == 0) ? data[7:4] : data[3:0];
            end
        end
        clk_q = clk_i;
    end

endmodule

//--- testbench/tb_spiflash.sv
`timescale 1ns/1ps
`include "spiflash_defines.svh"

module tb_spiflash;
    localparam int TIMEOUT = 2000;

    logic                        clk;
    logic                        resetn;
    logic                        valid;
    logic                        ready;
    logic [`SPIFLASH_ADDR_W-1:0] addr;
    logic [`SPIFLASH_DATA_W-1:0] rdata;
    logic [3:0]                  cfg_we;
    spiflash_pkg::cfgreg_u       cfg_wdata;
    spiflash_pkg::cfgreg_u       cfg_rdata;
    logic                        flash_csb;
    logic                        flash_clk;
    logic [3:0]                  flash_oe;
    logic [3:0]                  flash_do;
    logic [3:0]                  flash_di;
    logic [7:0]                  last_cmd;
    logic                        proto_err;
    logic [23:0]                 base;

    spiflash_top UUT (
        .clk           (clk),
        .resetn        (resetn),
        .valid_i       (valid),
        .ready_o       (ready),
        .addr_i        (addr),
        .rdata_o       (rdata),
        .cfg_we_i      (cfg_we),
        .cfg_wdata_i   (cfg_wdata),
        .cfg_rdata_o   (cfg_rdata),
        .flash_csb_o   (flash_csb),
        .flash_clk_o   (flash_clk),
        .flash_io_oe_o (flash_oe),
        .flash_io_do_o (flash_do),
        .flash_io_di_i (flash_di)
    );

    flash_model u_flash (
        .csb_i       (flash_csb),
        .clk_i       (flash_clk),
        .io_oe_i     (flash_oe),
        .io_do_i     (flash_do),
        .io_di_o     (flash_di),
        .last_cmd_o  (last_cmd),
        .proto_err_o (proto_err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // four bytes from a upward, lowest in the low lane
    function automatic logic [31:0] expected_word(input logic [23:0] a);
        logic [31:0] w;
        logic [23:0] b;
        for (int i = 0; i < 4; i++) begin
            b = a + 24'(i);
            w[i*8 +: 8] = b[7:0] ^ b[15:8] ^ 8'h5A;
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cfg(input string name, input spiflash_pkg::cfgreg_u got,
                             input spiflash_pkg::cfgreg_u exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic write_cfg(input logic [3:0] we, input spiflash_pkg::cfgreg_u data);
        @(posedge clk);
        cfg_we <= we;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 4'b0000;
    endtask

    task automatic read_word(input logic [23:0] a);
        int n;
        @(posedge clk);
        valid <= 1'b1;
        addr <= a;
        n = 0;
        @(negedge clk);
        while (!ready) begin
            n++;
            if (n > TIMEOUT) begin
                $display("ready_o never came for address %h", a);
                abort_run();
            end
            @(negedge clk);
        end
        check_word("rdata_o", rdata, expected_word(a));
        @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic reset_and_check();
        spiflash_pkg::cfgreg_u exp;
        exp = '0;
        exp.fields.en = 1'b1;
        exp.fields.dummy = 4'(`SPIFLASH_DUMMY_RST);
        exp.fields.csb = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("flash_csb_o", flash_csb, 1'b1);
        check_word("flash_io_oe_o", {28'h0, flash_oe}, 32'h0);
        check_cfg("cfg_rdata_o", cfg_rdata, exp);
        @(posedge clk);
        resetn <= 1'b1;
    endtask

    task automatic single_read();
        base = $urandom & 24'hFFFFFC;
        read_word(base);
        check_word("last command", {24'h0, last_cmd}, {24'h0, `SPIFLASH_CMD_READ});
    endtask

    task automatic sequential_reads();
        for (int i = 1; i <= 3; i++) begin
            read_word(base + 24'(4 * i));
        end
    endtask

    task automatic jump_read();
        read_word((base ^ 24'h400000) + 24'h000100);
    endtask

    task automatic quad_read();
        spiflash_pkg::cfgreg_u w;
        spiflash_pkg::cfgreg_u exp;
        w = '0;
        w.fields.qspi = 1'b1;
        w.fields.dummy = 4'(`SPIFLASH_DUMMY_RST);
        write_cfg(4'b0100, w);
        @(negedge clk);
        exp = '0;
        exp.fields.en = 1'b1;
        exp.fields.qspi = 1'b1;
        exp.fields.dummy = 4'(`SPIFLASH_DUMMY_RST);
        exp.fields.csb = flash_csb;
        exp.fields.clk = flash_clk;
        exp.fields.oe = flash_oe;
        exp.fields.dout = flash_di;
        check_cfg("cfg_rdata_o", cfg_rdata, exp);
        read_word($urandom & 24'hFFFFFC);
        check_word("last command", {24'h0, last_cmd}, {24'h0, `SPIFLASH_CMD_QREAD});
    endtask

    task automatic bitbang();
        spiflash_pkg::cfgreg_u w;
        spiflash_pkg::cfgreg_u exp;
        int n;
        w = '0;
        w.fields.dummy = 4'(`SPIFLASH_DUMMY_RST);
        w.fields.oe = 4'b0101;
        w.fields.csb = 1'b1;
        w.fields.clk = 1'b1;
        w.fields.dout = 4'b0011;
        write_cfg(4'b1111, w);
        n = 0;
        @(negedge clk);
        while (cfg_rdata.fields.en !== 1'b0) begin
            n++;
            if (n > TIMEOUT) begin
                $display("configuration write never took effect");
                abort_run();
            end
            @(negedge clk);
        end
        check_bit("flash_csb_o", flash_csb, 1'b1);
        check_bit("flash_clk_o", flash_clk, 1'b1);
        check_word("flash_io_oe_o", {28'h0, flash_oe}, 32'h5);
        check_word("flash_io_do_o", {28'h0, flash_do}, 32'h3);
        exp = w;
        exp.fields.dout = w.fields.oe & w.fields.dout;     // flash idle, drives zero
        check_cfg("cfg_rdata_o", cfg_rdata, exp);
        w.fields.csb = 1'b0;    // select from the register
        write_cfg(4'b0001, w);
        @(negedge clk);
        check_bit("flash_csb_o", flash_csb, 1'b0);
        exp.fields.csb = 1'b0;
        check_cfg("cfg_rdata_o", cfg_rdata, exp);
    endtask

    initial begin
        void'($urandom(32'h203cb5fa));
        resetn = 1'b0;
        valid = 1'b0;
        addr = '0;
        cfg_we = 4'b0000;
        cfg_wdata = '0;
        reset_and_check();
        single_read();
        sequential_reads();
        jump_read();
        quad_read();
        bitbang();
        check_bit("protocol error", proto_err, 1'b0);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/spiflash_pkg.sv
src/spiflash_cfg.sv
src/spiflash_xfer.sv
src/spiflash_seq.sv
src/spiflash_pads.sv
src/spiflash_top.sv
testbench/flash_model.sv
testbench/tb_spiflash.sv

//--- Bender.yml
package:
  name: spiflash

export_include_dirs:
  - src

sources:
  - src/spiflash_pkg.sv
  - src/spiflash_cfg.sv
  - src/spiflash_xfer.sv
  - src/spiflash_seq.sv
  - src/spiflash_pads.sv
  - src/spiflash_top.sv
  - target: test
    files:
      - testbench/flash_model.sv
      - testbench/tb_spiflash.sv
